// ==== croc_defs.svh ====
// Address map, bus widths and sizes of the SoC domain; included by the package and the RTL
`ifndef CROC_DEFS_SVH
`define CROC_DEFS_SVH

// ------------------------------------------------
// Bus widths
// ------------------------------------------------
`define CROC_ADDR_WIDTH 32
`define CROC_DATA_WIDTH 32
`define CROC_BE_WIDTH 4

// ------------------------------------------------
// Address map
// ------------------------------------------------
// 256 words give a 1 KiB bank, aliased across the whole SRAM region
`define CROC_SRAM_BASE 32'h1000_0000
`define CROC_SRAM_NUM_WORDS 256
`define CROC_SRAM_REGION_SIZE 32'h0001_0000

// Peripherals use 4 KiB windows
`define CROC_SOC_CTRL_BASE 32'h0300_0000
`define CROC_GPIO_BASE 32'h0300_5000
`define CROC_PERIPH_SIZE 32'h0000_1000

// Read data returned for unmapped addresses
`define CROC_ERR_RSP_DATA 32'hBADC_AB1E

// ------------------------------------------------
// GPIO and interrupts
// ------------------------------------------------
`define CROC_GPIO_COUNT 16
`define CROC_NUM_EXT_IRQS 4
`define CROC_NUM_IRQS 16
`define CROC_IRQ_GPIO_BIT 2
`define CROC_IRQ_EXT_LSB 3

`endif

// ==== croc_domain.sv ====
// Top level of the SoC domain; one bus manager port, demux, SRAM, control, GPIO and error subordinates
`include "croc_defs.svh"

module croc_domain (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  croc_pkg::obi_req_t            mgr_req_i,
  output croc_pkg::obi_rsp_t            mgr_rsp_o,
  input  logic [`CROC_GPIO_COUNT-1:0]   gpio_i,
  output logic [`CROC_GPIO_COUNT-1:0]   gpio_o,
  output logic [`CROC_GPIO_COUNT-1:0]   gpio_out_en_o,
  output logic [`CROC_GPIO_COUNT-1:0]   gpio_in_sync_o,
  input  logic                          fetch_en_i,
  input  logic [`CROC_NUM_EXT_IRQS-1:0] irqs_ext_i,
  output logic                          fetch_enable_o,
  output logic [`CROC_ADDR_WIDTH-1:0]   boot_addr_o,
  output logic [`CROC_NUM_IRQS-1:0]     irqs_o
);

  croc_pkg::obi_req_t [croc_pkg::NUM_SBR-1:0] sbr_req;
  croc_pkg::obi_rsp_t [croc_pkg::NUM_SBR-1:0] sbr_rsp;
  logic                                       gpio_irq;

  // Interrupt vector, unused lines tied low
  always_comb begin
    irqs_o                                               = '0;
    irqs_o[`CROC_IRQ_GPIO_BIT]                           = gpio_irq;
    irqs_o[`CROC_IRQ_EXT_LSB +: `CROC_NUM_EXT_IRQS]      = irqs_ext_i;
  end

  // ------------------------------------------------
  // Interconnect
  // ------------------------------------------------
  obi_periph_demux i_demux (
    .clk_i,
    .rst_n_i,
    .sbr_req_i ( mgr_req_i ),
    .sbr_rsp_o ( mgr_rsp_o ),
    .mgr_req_o ( sbr_req   ),
    .mgr_rsp_i ( sbr_rsp   )
  );

  // ------------------------------------------------
  // Subordinates
  // ------------------------------------------------
  obi_err_sbr i_err (
    .clk_i,
    .rst_n_i,
    .req_i ( sbr_req[croc_pkg::SbrError] ),
    .rsp_o ( sbr_rsp[croc_pkg::SbrError] )
  );

  sram_bank i_sram (
    .clk_i,
    .rst_n_i,
    .req_i ( sbr_req[croc_pkg::SbrSram] ),
    .rsp_o ( sbr_rsp[croc_pkg::SbrSram] )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .req_i          ( sbr_req[croc_pkg::SbrSocCtrl] ),
    .rsp_o          ( sbr_rsp[croc_pkg::SbrSocCtrl] ),
    .fetch_en_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  gpio_ctrl #(
    .GpioCount ( `CROC_GPIO_COUNT )
  ) i_gpio (
    .clk_i,
    .rst_n_i,
    .req_i          ( sbr_req[croc_pkg::SbrGpio] ),
    .rsp_o          ( sbr_rsp[croc_pkg::SbrGpio] ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq )
  );

endmodule

// ==== croc_pkg.sv ====
// Bus channel types and subordinate indices shared by every module of the SoC domain
`include "croc_defs.svh"

package croc_pkg;

  // ------------------------------------------------
  // Request side
  // ------------------------------------------------
  // Address channel, 69 bits
  typedef struct packed {
    logic [`CROC_ADDR_WIDTH-1:0] addr;
    logic                        we;
    logic [`CROC_BE_WIDTH-1:0]   be;
    logic [`CROC_DATA_WIDTH-1:0] wdata;
  } obi_a_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  // ------------------------------------------------
  // Response side
  // ------------------------------------------------
  // Response channel, 33 bits
  typedef struct packed {
    logic [`CROC_DATA_WIDTH-1:0] rdata;
    logic                        err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

  // ------------------------------------------------
  // Subordinates behind the demux
  // ------------------------------------------------
  typedef enum logic [1:0] {
    SbrError   = 2'd0,
    SbrSram    = 2'd1,
    SbrSocCtrl = 2'd2,
    SbrGpio    = 2'd3
  } sbr_idx_e;

  localparam int unsigned NUM_SBR = 4;

endpackage

// ==== gpio_ctrl.sv ====
// GPIO block; direction and output registers, synchronized inputs and rising-edge interrupts
`include "croc_defs.svh"

module gpio_ctrl #(
  parameter int unsigned GpioCount = `CROC_GPIO_COUNT
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  croc_pkg::obi_req_t   req_i,
  output croc_pkg::obi_rsp_t   rsp_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 irq_o
);

  localparam logic [11:0] DIR_OFFSET = 12'h000;
  localparam logic [11:0] OUT_OFFSET = 12'h004;
  localparam logic [11:0] IN_OFFSET = 12'h008;
  localparam logic [11:0] IRQ_EN_OFFSET = 12'h00C;
  localparam logic [11:0] IRQ_STATUS_OFFSET = 12'h010;

  logic [GpioCount-1:0]        dir_q, out_q, irq_en_q, irq_status_q;
  logic [GpioCount-1:0]        sync1_q, sync2_q, prev_q;
  logic [GpioCount-1:0]        rise;
  logic [`CROC_DATA_WIDTH-1:0] wmask, wbits;
  logic [`CROC_DATA_WIDTH-1:0] rdata_d, rdata_q;
  logic                        rvalid_q;
  logic [11:0]                 offset;
  logic                        wr_en;

  assign offset = req_i.a.addr[11:0];
  assign wr_en  = req_i.req && req_i.a.we;

  // Byte enables expanded to a bit mask
  always_comb begin
    for (int b = 0; b < `CROC_BE_WIDTH; b++) begin
      wmask[8*b +: 8] = {8{req_i.a.be[b]}};
    end
  end
  assign wbits = req_i.a.wdata & wmask;

  // ------------------------------------------------
  // Input sync and edge detect
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end
  assign rise = sync2_q & ~prev_q;

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q        <= '0;
      out_q        <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en && offset == DIR_OFFSET) begin
        dir_q <= (dir_q & ~wmask[GpioCount-1:0]) | wbits[GpioCount-1:0];
      end
      if (wr_en && offset == OUT_OFFSET) begin
        out_q <= (out_q & ~wmask[GpioCount-1:0]) | wbits[GpioCount-1:0];
      end
      if (wr_en && offset == IRQ_EN_OFFSET) begin
        irq_en_q <= (irq_en_q & ~wmask[GpioCount-1:0]) | wbits[GpioCount-1:0];
      end
      // New edges win over a clear in the same cycle
      if (wr_en && offset == IRQ_STATUS_OFFSET) begin
        irq_status_q <= (irq_status_q & ~wbits[GpioCount-1:0]) | (rise & irq_en_q);
      end else begin
        irq_status_q <= irq_status_q | (rise & irq_en_q);
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    case (offset)
      DIR_OFFSET:        rdata_d[GpioCount-1:0] = dir_q;
      OUT_OFFSET:        rdata_d[GpioCount-1:0] = out_q;
      IN_OFFSET:         rdata_d[GpioCount-1:0] = sync2_q;
      IRQ_EN_OFFSET:     rdata_d[GpioCount-1:0] = irq_en_q;
      IRQ_STATUS_OFFSET: rdata_d[GpioCount-1:0] = irq_status_q;
      default:           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.a.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.rvalid  = rvalid_q;
  assign rsp_o.r.rdata = rdata_q;
  assign rsp_o.r.err   = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |irq_status_q;

  // Status bits only set where the enable was on
  a_status_needs_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((irq_status_q & ~$past(irq_status_q)) & ~$past(irq_en_q)) == '0);

endmodule

// ==== obi_err_sbr.sv ====
// Error subordinate; answers every transfer with the error flag and a fixed data word
`include "croc_defs.svh"

module obi_err_sbr (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  croc_pkg::obi_req_t req_i,
  output croc_pkg::obi_rsp_t rsp_o
);

  logic rvalid_q;

  // Reads and writes get the same answer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.rvalid  = rvalid_q;
  assign rsp_o.r.rdata = `CROC_ERR_RSP_DATA;
  assign rsp_o.r.err   = 1'b1;

  // Back-to-back responses need back-to-back requests
  a_rvalid_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rsp_o.rvalid && $past(rsp_o.rvalid)) |-> ($past(req_i.req, 1) && $past(req_i.req, 2)));

endmodule

// ==== obi_periph_demux.sv ====
// Single-manager bus demux; decodes the address and returns each response from its subordinate
`include "croc_defs.svh"

module obi_periph_demux (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  croc_pkg::obi_req_t                        sbr_req_i,
  output croc_pkg::obi_rsp_t                        sbr_rsp_o,
  output croc_pkg::obi_req_t [croc_pkg::NUM_SBR-1:0] mgr_req_o,
  input  croc_pkg::obi_rsp_t [croc_pkg::NUM_SBR-1:0] mgr_rsp_i
);

  localparam logic [`CROC_ADDR_WIDTH-1:0] SRAM_END = `CROC_SRAM_BASE + `CROC_SRAM_REGION_SIZE;
  localparam logic [`CROC_ADDR_WIDTH-1:0] SOC_CTRL_END = `CROC_SOC_CTRL_BASE + `CROC_PERIPH_SIZE;
  localparam logic [`CROC_ADDR_WIDTH-1:0] GPIO_END = `CROC_GPIO_BASE + `CROC_PERIPH_SIZE;

  croc_pkg::sbr_idx_e sel;
  croc_pkg::sbr_idx_e rsp_idx_q;
  logic               rsp_pending_q;
  logic               accept;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  always_comb begin
    // Unmapped addresses fall through to the error subordinate
    sel = croc_pkg::SbrError;
    if (sbr_req_i.a.addr >= `CROC_SRAM_BASE && sbr_req_i.a.addr < SRAM_END) begin
      sel = croc_pkg::SbrSram;
    end else if (sbr_req_i.a.addr >= `CROC_SOC_CTRL_BASE && sbr_req_i.a.addr < SOC_CTRL_END) begin
      sel = croc_pkg::SbrSocCtrl;
    end else if (sbr_req_i.a.addr >= `CROC_GPIO_BASE && sbr_req_i.a.addr < GPIO_END) begin
      sel = croc_pkg::SbrGpio;
    end
  end

  // Request fanout, the a channel goes to everyone
  always_comb begin
    for (int i = 0; i < croc_pkg::NUM_SBR; i++) begin
      mgr_req_o[i].req = sbr_req_i.req && (sel == croc_pkg::sbr_idx_e'(i));
      mgr_req_o[i].a   = sbr_req_i.a;
    end
  end

  assign accept = sbr_req_i.req && mgr_rsp_i[sel].gnt;

  // ------------------------------------------------
  // Response steering
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_pending_q <= 1'b0;
      rsp_idx_q     <= croc_pkg::SbrError;
    end else begin
      rsp_pending_q <= accept;
      if (accept) begin
        rsp_idx_q <= sel;
      end
    end
  end

  assign sbr_rsp_o.gnt    = mgr_rsp_i[sel].gnt;
  assign sbr_rsp_o.rvalid = rsp_pending_q && mgr_rsp_i[rsp_idx_q].rvalid;
  assign sbr_rsp_o.r      = mgr_rsp_i[rsp_idx_q].r;

  // A subordinate answers only a transfer it accepted the cycle before
  for (genvar i = 0; i < croc_pkg::NUM_SBR; i++) begin : gen_rvalid_chk
    a_rvalid_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mgr_rsp_i[i].rvalid |-> $past(mgr_req_o[i].req && mgr_rsp_i[i].gnt));
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SoC domain testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
  -f sources.f --top-module tb_croc_domain -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_croc_domain 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -q "No errors"; then
  echo "PASS"
  exit 0
else
  echo "FAIL: pass message not found"
  exit 1
fi

// ==== soc_ctrl_regs.sv ====
// SoC control registers; boot address and fetch enable, read and written over the bus
`include "croc_defs.svh"

module soc_ctrl_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  croc_pkg::obi_req_t          req_i,
  output croc_pkg::obi_rsp_t          rsp_o,
  input  logic                        fetch_en_i,
  output logic                        fetch_enable_o,
  output logic [`CROC_ADDR_WIDTH-1:0] boot_addr_o
);

  localparam logic [11:0] BOOT_ADDR_OFFSET = 12'h000;
  localparam logic [11:0] FETCH_EN_OFFSET = 12'h004;

  logic [`CROC_ADDR_WIDTH-1:0] boot_addr_q;
  logic                        fetch_en_q;
  logic [`CROC_DATA_WIDTH-1:0] rdata_d;
  logic [`CROC_DATA_WIDTH-1:0] rdata_q;
  logic                        rvalid_q;
  logic [11:0]                 offset;
  logic                        wr_en;

  assign offset = req_i.a.addr[11:0];
  assign wr_en  = req_i.req && req_i.a.we;

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= `CROC_SRAM_BASE;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en && offset == BOOT_ADDR_OFFSET) begin
        for (int b = 0; b < `CROC_BE_WIDTH; b++) begin
          if (req_i.a.be[b]) begin
            boot_addr_q[8*b +: 8] <= req_i.a.wdata[8*b +: 8];
          end
        end
      end
      // Only bit 0 is implemented
      if (wr_en && offset == FETCH_EN_OFFSET && req_i.a.be[0]) begin
        fetch_en_q <= req_i.a.wdata[0];
      end
    end
  end

  // Read mux, unknown offsets read zero
  always_comb begin
    rdata_d = '0;
    case (offset)
      BOOT_ADDR_OFFSET: rdata_d = boot_addr_q;
      FETCH_EN_OFFSET:  rdata_d[0] = fetch_en_q;
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.a.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.rvalid  = rvalid_q;
  assign rsp_o.r.rdata = rdata_q;
  assign rsp_o.r.err   = 1'b0;

  // External pin can start the core without a register write
  assign fetch_enable_o = fetch_en_q | fetch_en_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

// ==== sources.f ====
+incdir+.
croc_pkg.sv
obi_periph_demux.sv
sram_bank.sv
obi_err_sbr.sv
soc_ctrl_regs.sv
gpio_ctrl.sv
croc_domain.sv
tb_croc_domain.sv

// ==== sram_bank.sv ====
// Single-port SRAM bank with byte enables behind a bus shim; one cycle of read latency
`include "croc_defs.svh"

module sram_bank (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  croc_pkg::obi_req_t req_i,
  output croc_pkg::obi_rsp_t rsp_o
);

  localparam int unsigned IDX_WIDTH = $clog2(`CROC_SRAM_NUM_WORDS);

  logic [`CROC_DATA_WIDTH-1:0] mem [`CROC_SRAM_NUM_WORDS];
  logic [IDX_WIDTH-1:0]        word_idx;
  logic [`CROC_DATA_WIDTH-1:0] rdata_q;
  logic                        rvalid_q;

  // Word index above the byte offset, wraps inside the bank
  assign word_idx = req_i.a.addr[2 +: IDX_WIDTH];

  // ------------------------------------------------
  // Memory array
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.a.we) begin
        for (int b = 0; b < `CROC_BE_WIDTH; b++) begin
          if (req_i.a.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.a.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // Shim side, always ready
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.rvalid  = rvalid_q;
  assign rsp_o.r.rdata = rdata_q;
  assign rsp_o.r.err   = 1'b0;

  // Every request is granted at once and answered on the next cycle
  a_grant_then_answer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |-> rsp_o.gnt ##1 rsp_o.rvalid);

endmodule

// ==== tb_croc_domain.sv ====
// Testbench for the SoC domain; acts as bus manager and checks every response and pin with assertions
`include "croc_defs.svh"

module tb_croc_domain;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;
  localparam int RND_OPS = 40;
  // All tests take about 450 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int T_ERR = 0;
  localparam int T_SRAM = 1;
  localparam int T_CTRL = 2;
  localparam int T_GPIO = 3;

  logic                            clk_i;
  logic                            rst_n_i;
  croc_pkg::obi_req_t              mgr_req_i;
  croc_pkg::obi_rsp_t              mgr_rsp_o;
  logic [`CROC_GPIO_COUNT-1:0]     gpio_i, gpio_o, gpio_out_en_o, gpio_in_sync_o;
  logic                            fetch_en_i, fetch_enable_o;
  logic [`CROC_NUM_EXT_IRQS-1:0]   irqs_ext_i;
  logic [`CROC_ADDR_WIDTH-1:0]     boot_addr_o;
  logic [`CROC_NUM_IRQS-1:0]       irqs_o;

  // Reference model
  logic [31:0]                 m_sram [`CROC_SRAM_NUM_WORDS];
  logic [31:0]                 m_boot;
  logic                        m_fetch;
  logic [`CROC_GPIO_COUNT-1:0] m_dir, m_out, m_irq_en, m_status;
  logic [`CROC_GPIO_COUNT-1:0] m_sync1, m_sync2, m_prev, irq_clr;
  logic [31:0]                 hs_addr, merged, exp_rdata_q;
  logic                        exp_err_q, exp_chk_q;
  logic [`CROC_NUM_IRQS-1:0]   exp_irqs;
  logic [31:0]                 lfsr_q;
  int                          cycle_count = 0;

  croc_domain dut0 (.*);

  always #20 clk_i = ~clk_i;

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
    stop_on_failure("DUT value differs from the reference model");
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Byte-enabled write into one GPIO register
  function automatic logic [`CROC_GPIO_COUNT-1:0] update_gpio_reg(
      input logic [`CROC_GPIO_COUNT-1:0] old_r, input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] full;
    full = merge_bytes(32'(old_r), wdata, be);
    return full[`CROC_GPIO_COUNT-1:0];
  endfunction

  // Address map decode
  function automatic int target_of(input logic [31:0] addr);
    if (addr >= `CROC_SRAM_BASE && addr < `CROC_SRAM_BASE + `CROC_SRAM_REGION_SIZE) begin
      return T_SRAM;
    end else if (addr >= `CROC_SOC_CTRL_BASE && addr < `CROC_SOC_CTRL_BASE + `CROC_PERIPH_SIZE) begin
      return T_CTRL;
    end else if (addr >= `CROC_GPIO_BASE && addr < `CROC_GPIO_BASE + `CROC_PERIPH_SIZE) begin
      return T_GPIO;
    end
    return T_ERR;
  endfunction

  // Bank aliases every 1 KiB, so bits 9:2 pick the word
  function automatic logic [31:0] read_model(input logic [31:0] addr);
    logic [31:0] val;
    val = '0;
    case (target_of(addr))
      T_SRAM: val = m_sram[addr[9:2]];
      T_CTRL: begin
        if (addr[11:0] == 12'h000) begin
          val = m_boot;
        end else if (addr[11:0] == 12'h004) begin
          val = {31'h0, m_fetch};
        end
      end
      T_GPIO: begin
        case (addr[11:0])
          12'h000: val = 32'(m_dir);
          12'h004: val = 32'(m_out);
          12'h008: val = 32'(m_sync2);
          12'h00C: val = 32'(m_irq_en);
          12'h010: val = 32'(m_status);
          default: val = '0;
        endcase
      end
      default: val = `CROC_ERR_RSP_DATA;
    endcase
    return val;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  // One transfer; returns 5 ns after the handshake edge with req low
  task automatic transfer(input logic [31:0] addr, input logic we, input logic [3:0] be,
                          input logic [31:0] wdata);
    mgr_req_i.req     = 1'b1;
    mgr_req_i.a.addr  = addr;
    mgr_req_i.a.we    = we;
    mgr_req_i.a.be    = be;
    mgr_req_i.a.wdata = wdata;
    @(posedge clk_i);
    while (!mgr_rsp_o.gnt) begin
      @(posedge clk_i);
    end
    #5;
    mgr_req_i.req = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [3:0] be, input logic [31:0] d);
    transfer(addr, 1'b1, be, d);
  endtask

  task automatic read_word(input logic [31:0] addr);
    transfer(addr, 1'b0, 4'hF, 32'h0);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #5;
  endtask

  // ------------------------------------------------
  // Reference model, updated on each handshake
  // ------------------------------------------------
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      m_boot      <= `CROC_SRAM_BASE;
      m_fetch     <= 1'b0;
      m_dir       <= '0;
      m_out       <= '0;
      m_irq_en    <= '0;
      m_status    <= '0;
      m_sync1     <= '0;
      m_sync2     <= '0;
      m_prev      <= '0;
      exp_rdata_q <= '0;
      exp_err_q   <= 1'b0;
      exp_chk_q   <= 1'b0;
    end else begin
      irq_clr = '0;
      m_sync1 <= gpio_i;
      m_sync2 <= m_sync1;
      m_prev  <= m_sync2;
      if (mgr_req_i.req && mgr_rsp_o.gnt) begin
        hs_addr = mgr_req_i.a.addr;
        exp_rdata_q <= read_model(hs_addr);
        exp_err_q   <= (target_of(hs_addr) == T_ERR);
        exp_chk_q   <= !mgr_req_i.a.we;
        if (mgr_req_i.a.we) begin
          case (target_of(hs_addr))
            T_SRAM: begin
              m_sram[hs_addr[9:2]] <= merge_bytes(m_sram[hs_addr[9:2]], mgr_req_i.a.wdata,
                                                  mgr_req_i.a.be);
            end
            T_CTRL: begin
              if (hs_addr[11:0] == 12'h000) begin
                m_boot <= merge_bytes(m_boot, mgr_req_i.a.wdata, mgr_req_i.a.be);
              end else if (hs_addr[11:0] == 12'h004 && mgr_req_i.a.be[0]) begin
                m_fetch <= mgr_req_i.a.wdata[0];
              end
            end
            T_GPIO: begin
              merged = merge_bytes(32'h0, mgr_req_i.a.wdata, mgr_req_i.a.be);
              case (hs_addr[11:0])
                12'h000: m_dir <= update_gpio_reg(m_dir, mgr_req_i.a.wdata, mgr_req_i.a.be);
                12'h004: m_out <= update_gpio_reg(m_out, mgr_req_i.a.wdata, mgr_req_i.a.be);
                12'h00C: m_irq_en <= update_gpio_reg(m_irq_en, mgr_req_i.a.wdata,
                                                     mgr_req_i.a.be);
                12'h010: irq_clr = merged[15:0];
                default: ;
              endcase
            end
            default: ;
          endcase
        end
      end
      // Sticky rising edges of enabled pins, ones written to status clear
      m_status <= (m_status & ~irq_clr) | (m_sync2 & ~m_prev & m_irq_en);
    end
  end

  always_comb begin
    exp_irqs = '0;
    exp_irqs[`CROC_IRQ_GPIO_BIT] = |m_status;
    exp_irqs[`CROC_IRQ_EXT_LSB +: `CROC_NUM_EXT_IRQS] = irqs_ext_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_failure("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mgr_rsp_o.gnt == mgr_req_i.req)
    else report_mismatch("mgr_rsp_o.gnt", 32'($sampled(mgr_rsp_o.gnt)),
                         32'($sampled(mgr_req_i.req)));
  a_rvalid_after_hs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mgr_req_i.req && mgr_rsp_o.gnt) |=> mgr_rsp_o.rvalid)
    else stop_on_failure("rvalid missing one cycle after a handshake");
  a_no_spurious_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mgr_rsp_o.rvalid |-> $past(mgr_req_i.req && mgr_rsp_o.gnt))
    else stop_on_failure("rvalid rose without a handshake in the previous cycle");
  a_rsp_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mgr_rsp_o.rvalid |-> mgr_rsp_o.r.err == exp_err_q)
    else report_mismatch("mgr_rsp_o.r.err", 32'($sampled(mgr_rsp_o.r.err)),
                         32'($sampled(exp_err_q)));
  a_rsp_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mgr_rsp_o.rvalid && exp_chk_q) |-> mgr_rsp_o.r.rdata == exp_rdata_q)
    else report_mismatch("mgr_rsp_o.r.rdata", $sampled(mgr_rsp_o.r.rdata),
                         $sampled(exp_rdata_q));
  a_boot_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    boot_addr_o == m_boot)
    else report_mismatch("boot_addr_o", $sampled(boot_addr_o), $sampled(m_boot));
  a_fetch_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_enable_o == (m_fetch | fetch_en_i))
    else report_mismatch("fetch_enable_o", 32'($sampled(fetch_enable_o)),
                         32'($sampled(m_fetch | fetch_en_i)));
  a_gpio_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gpio_o == m_out)
    else report_mismatch("gpio_o", 32'($sampled(gpio_o)), 32'($sampled(m_out)));
  a_gpio_dir: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gpio_out_en_o == m_dir)
    else report_mismatch("gpio_out_en_o", 32'($sampled(gpio_out_en_o)), 32'($sampled(m_dir)));
  a_gpio_sync: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gpio_in_sync_o == m_sync2)
    else report_mismatch("gpio_in_sync_o", 32'($sampled(gpio_in_sync_o)),
                         32'($sampled(m_sync2)));
  a_irqs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irqs_o == exp_irqs)
    else report_mismatch("irqs_o", 32'($sampled(irqs_o)), 32'($sampled(exp_irqs)));

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] bits;
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    mgr_req_i  = '0;
    gpio_i     = '0;
    fetch_en_i = 1'b0;
    irqs_ext_i = '0;
    lfsr_q     = 32'd87764;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;
    fetch_en_i = 1'b1;
    wait_cycles(2);
    fetch_en_i = 1'b0;
    wait_cycles(1);

    // SRAM fill, then random byte writes and reads over the whole region
    for (int i = 0; i < `CROC_SRAM_NUM_WORDS; i++) begin
      addr = `CROC_SRAM_BASE + 32'(4 * i);
      write_word(addr, 4'hF, fill_word(addr));
    end
    for (int i = 0; i < RND_OPS; i++) begin
      take_bits(14, bits);
      addr = `CROC_SRAM_BASE + {bits[29:0], 2'b00};
      take_bits(4, bits);
      take_bits(32, data);
      write_word(addr, bits[3:0], data);
    end
    for (int i = 0; i < RND_OPS; i++) begin
      take_bits(14, bits);
      read_word(`CROC_SRAM_BASE + {bits[29:0], 2'b00});
    end

    // Unmapped addresses
    read_word(32'h0000_0000);
    write_word(32'h2000_0000, 4'hF, 32'h1234_5678);
    read_word(32'h0300_1000);
    read_word(`CROC_SRAM_BASE + `CROC_SRAM_REGION_SIZE);
    read_word(32'hFFFF_FFFC);

    // SoC control
    take_bits(32, data);
    write_word(`CROC_SOC_CTRL_BASE, 4'hF, data);
    take_bits(32, data);
    write_word(`CROC_SOC_CTRL_BASE, 4'b0101, data);
    read_word(`CROC_SOC_CTRL_BASE);
    write_word(`CROC_SOC_CTRL_BASE + 32'h4, 4'h1, 32'h1);
    read_word(`CROC_SOC_CTRL_BASE + 32'h4);
    fetch_en_i = 1'b1;
    wait_cycles(2);
    write_word(`CROC_SOC_CTRL_BASE + 32'h4, 4'h1, 32'h0);
    write_word(`CROC_SOC_CTRL_BASE + 32'h4, 4'hE, 32'h1);
    read_word(`CROC_SOC_CTRL_BASE + 32'h4);
    fetch_en_i = 1'b0;
    write_word(`CROC_SOC_CTRL_BASE + 32'h8, 4'hF, 32'hFFFF_FFFF);
    read_word(`CROC_SOC_CTRL_BASE + 32'h8);

    // GPIO pins
    take_bits(16, data);
    write_word(`CROC_GPIO_BASE, 4'h3, data);
    take_bits(16, data);
    write_word(`CROC_GPIO_BASE + 32'h4, 4'hF, data);
    write_word(`CROC_GPIO_BASE + 32'h4, 4'h2, 32'h0);
    read_word(`CROC_GPIO_BASE);
    read_word(`CROC_GPIO_BASE + 32'h4);
    take_bits(16, data);
    gpio_i = data[`CROC_GPIO_COUNT-1:0];
    wait_cycles(3);
    read_word(`CROC_GPIO_BASE + 32'h8);

    // Interrupts, pin 0 enabled and pin 8 not
    gpio_i = '0;
    wait_cycles(4);
    write_word(`CROC_GPIO_BASE + 32'hC, 4'hF, 32'h0000_00FF);
    gpio_i = 16'h0101;
    wait_cycles(4);
    read_word(`CROC_GPIO_BASE + 32'h10);
    write_word(`CROC_GPIO_BASE + 32'h10, 4'hF, 32'h0000_0001);
    read_word(`CROC_GPIO_BASE + 32'h10);
    for (int i = 0; i < 4; i++) begin
      take_bits(4, bits);
      irqs_ext_i = bits[`CROC_NUM_EXT_IRQS-1:0];
      wait_cycles(1);
    end

    // Back-to-back transfers across subordinates
    take_bits(32, data);
    write_word(`CROC_SRAM_BASE + 32'h40, 4'hF, data);
    read_word(`CROC_GPIO_BASE + 32'h4);
    read_word(`CROC_SRAM_BASE + 32'h40);
    read_word(32'h0000_1000);
    read_word(`CROC_SOC_CTRL_BASE);
    read_word(`CROC_GPIO_BASE + 32'h8);
    wait_cycles(3);
    $display("No errors");
    $finish;
  end

endmodule
